// ==== filelist.f ====
+incdir+.
sync_pkg.sv
cic_decimator.sv
pss_correlator.sv
ssb_frame_sync.sv
symbol_energy.sv
ssb_sync_top.sv
ssb_sync_props.sv
tb_ssb_sync_top.sv

// ==== Bender.yml ====
package:
  name: ssb_sync

export_include_dirs:
  - .

sources:
  - sync_pkg.sv
  - cic_decimator.sv
  - pss_correlator.sv
  - ssb_frame_sync.sv
  - symbol_energy.sv
  - ssb_sync_top.sv
  - target: test
    files:
      - ssb_sync_props.sv
      - tb_ssb_sync_top.sv

// ==== tb_ssb_sync_top.sv ====
`timescale 1ns/1ps
`include "sync_params.svh"

module tb_ssb_sync_top;

    localparam int TEST_CYCLES = 1080;                  // Summed length of all tests
    localparam int LIMIT       = 3 * TEST_CYCLES;
    localparam logic [15:0] TAPS = `SYNC_PSS_TAPS;

    logic                 clk_i;
    logic                 rst_n_i;
    sync_pkg::in_sample_t in_data_i;
    logic                 in_valid_i;
    sync_pkg::sample_t    cic_data_o;
    logic                 cic_valid_o;
    logic                 peak_o;
    logic                 ssb_start_o;
    sync_pkg::energy_t    energy_o;
    logic                 energy_valid_o;
    logic                 pbch_valid_o;
    logic                 sss_valid_o;

    // Reference model state
    int          h_re [3];
    int          h_im [3];
    int          l_re [16];
    int          l_im [16];
    logic        phase;
    int          fs_mode;
    int          fs_cnt;
    int          fs_idx;
    int          acc;
    logic [31:0] exp_cic [$];
    logic        exp_peak [$];
    logic [25:0] exp_energy [$];

    // Monitor state
    logic        mon_on;
    logic        cic_seen;
    int          peaks_seen;
    int          energies_seen;
    int          starts_seen;
    logic [1:0]  cls_seen [$];
    int          cycles;
    logic [31:0] lfsr;
    string       test_name;

    ssb_sync_top uut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_data_i      (in_data_i),
        .in_valid_i     (in_valid_i),
        .cic_data_o     (cic_data_o),
        .cic_valid_o    (cic_valid_o),
        .peak_o         (peak_o),
        .ssb_start_o    (ssb_start_o),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_valid_o    (sss_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("Done: errors found");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Fail %s %s expected %0h actual %0h", test_name, what, exp, act));
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles > LIMIT) begin
                fail_run($sformatf("Timeout: run went past %0d cycles", LIMIT));
            end
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int iabs(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // ******************************
    // Reference model
    // ******************************
    function automatic int cic_rule(input int x0, input int x1, input int x2, input int x3);
        return (x0 + 3 * x1 + 3 * x2 + x3) >>> 3;       // 1,3,3,1 weights
    endfunction

    task automatic frame_rule(input int dre, input int dim, input logic pk);
        case (fs_mode)
            0: if (pk) begin
                fs_mode = 1;
                fs_cnt  = 0;
                fs_idx  = 1;
            end
            1: begin
                fs_cnt++;
                if (fs_cnt == `SYNC_CP_LEN) begin
                    fs_mode = 2;
                    fs_cnt  = 0;
                end
            end
            default: begin
                acc = acc + iabs(dre) + iabs(dim);
                fs_cnt++;
                if (fs_cnt == `SYNC_SYM_LEN) begin
                    exp_energy.push_back({acc[23:0], fs_idx != 2, fs_idx == 2});
                    acc    = 0;
                    fs_cnt = 0;
                    if (fs_idx == `SYNC_SSB_SYMS) begin
                        fs_mode = 0;
                    end else begin
                        fs_mode = 1;
                        fs_idx++;
                    end
                end
            end
        endcase
    endtask

    task automatic corr_rule(input int dre, input int dim);
        int   cr;
        int   ci;
        logic pk;
        cr = 0;
        ci = 0;
        for (int k = 0; k < 15; k++) begin
            l_re[k] = l_re[k + 1];
            l_im[k] = l_im[k + 1];
        end
        l_re[15] = dre;
        l_im[15] = dim;
        for (int k = 0; k < 16; k++) begin
            cr = TAPS[k] ? cr + l_re[k] : cr - l_re[k];
            ci = TAPS[k] ? ci + l_im[k] : ci - l_im[k];
        end
        pk = (iabs(cr) + iabs(ci)) >= `SYNC_THRESH;
        exp_peak.push_back(pk);
        frame_rule(dre, dim, pk);
    endtask

    task automatic model_input(input int re, input int im);
        int dre;
        int dim;
        if (phase) begin
            dre = cic_rule(re, h_re[0], h_re[1], h_re[2]);
            dim = cic_rule(im, h_im[0], h_im[1], h_im[2]);
            exp_cic.push_back({dim[15:0], dre[15:0]});
            corr_rule(dre, dim);
        end
        h_re[2] = h_re[1];
        h_re[1] = h_re[0];
        h_re[0] = re;
        h_im[2] = h_im[1];
        h_im[1] = h_im[0];
        h_im[0] = im;
        phase   = !phase;
    endtask

    // ******************************
    // Output monitor
    // ******************************
    always @(negedge clk_i) begin
        if (mon_on) begin
            if (cic_valid_o) begin
                if (exp_cic.size() == 0) fail_run("CIC produced an output that was not expected");
                check("cic", exp_cic.pop_front(), cic_data_o);
            end
            if (cic_seen) begin
                if (exp_peak.size() == 0) fail_run("Correlator result came with no model entry");
                check("peak", exp_peak.pop_front(), peak_o);
            end else begin
                check("peak idle", 0, peak_o);
            end
            if (peak_o) peaks_seen++;
            if (ssb_start_o) starts_seen++;
            if (energy_valid_o) begin
                if (exp_energy.size() == 0) fail_run("Energy output appeared that was not expected");
                check("energy", exp_energy.pop_front(), {energy_o, pbch_valid_o, sss_valid_o});
                energies_seen++;
                cls_seen.push_back({pbch_valid_o, sss_valid_o});
            end else begin
                check("class idle", 0, {pbch_valid_o, sss_valid_o});
            end
            cic_seen = cic_valid_o;
        end
    end

    // One full-rate sample per falling edge
    task automatic send(input int re, input int im);
        @(negedge clk_i);
        in_data_i.re = re[`SYNC_IN_W-1:0];
        in_data_i.im = im[`SYNC_IN_W-1:0];
        in_valid_i   = 1'b1;
        model_input(re, im);
    endtask

    task automatic send_const(input int n, input int re, input int im);
        for (int i = 0; i < n; i++) send(re, im);
    endtask

    task automatic send_replica(input int a);
        int v;
        for (int k = 0; k < 16; k++) begin
            v = TAPS[k] ? a : -a;
            send(v, v);                                 // Chip held for two inputs
            send(v, v);
        end
    endtask

    task automatic wait_drain();
        @(negedge clk_i);
        in_valid_i = 1'b0;
        in_data_i  = '0;
        while (exp_cic.size() != 0 || exp_peak.size() != 0 || exp_energy.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (6) @(negedge clk_i);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        peaks_seen    = 0;
        energies_seen = 0;
        starts_seen   = 0;
        cls_seen.delete();
    endtask

    // ******************************
    // Directed tests
    // ******************************
    task automatic idle_after_reset();
        start_test("idle");
        repeat (10) @(negedge clk_i);
        check("peaks", 0, peaks_seen);
        check("energies", 0, energies_seen);
        check("starts", 0, starts_seen);
    endtask

    task automatic cic_impulse_step();
        start_test("cic");
        send(1000, -800);                               // Impulse
        send_const(7, 0, 0);
        send_const(16, 600, -300);                      // Step
        send_const(8, 0, 0);
        wait_drain();
        check("peaks", 0, peaks_seen);
    endtask

    task automatic replica_detection();
        start_test("detect");
        send_const(32, 0, 0);
        send_replica(400);
        send_const(140, 0, 0);
        wait_drain();
        check("peak seen", 1, peaks_seen != 0);
    endtask

    task automatic ss_block_energies();
        start_test("block");
        send_const(32, 0, 0);
        send_replica(400);
        send_const(40, 300, 0);
        send_const(40, 600, 0);
        send_const(40, 900, 0);
        send_const(40, 0, 0);
        wait_drain();
        check("energies", 3, energies_seen);
        check("starts", 1, starts_seen);
        check("class 1", 2'b10, cls_seen[0]);
        check("class 2", 2'b01, cls_seen[1]);
        check("class 3", 2'b10, cls_seen[2]);
    endtask

    task automatic inner_pss_ignored();
        start_test("restart");
        send_const(32, 0, 0);
        send_replica(400);
        send_const(40, 500, 0);
        send_replica(400);                              // Lands inside symbol 2
        send_const(80, 800, 0);
        send_const(60, 0, 0);
        wait_drain();
        check("energies", 3, energies_seen);
        check("starts", 1, starts_seen);
    endtask

    task automatic noise_rejection();
        int re;
        int im;
        start_test("noise");
        for (int i = 0; i < 200; i++) begin
            re = int'(draw_bits(6)) - 32;
            im = int'(draw_bits(6)) - 32;
            send(re, im);
        end
        send_const(20, 0, 0);
        wait_drain();
        check("peaks", 0, peaks_seen);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        mon_on      = 1'b0;
        cic_seen    = 1'b0;
        phase       = 1'b0;
        fs_mode     = 0;
        fs_cnt      = 0;
        fs_idx      = 0;
        acc         = 0;
        lfsr        = 32'ha8c7_b4d2;
        test_name   = "reset";
        for (int k = 0; k < 16; k++) begin
            l_re[k] = 0;
            l_im[k] = 0;
        end
        for (int k = 0; k < 3; k++) begin
            h_re[k] = 0;
            h_im[k] = 0;
        end
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;
        mon_on  = 1'b1;
        idle_after_reset();
        cic_impulse_step();
        replica_detection();
        ss_block_energies();
        inner_pss_ignored();
        noise_rejection();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== ssb_sync_props.sv ====
`timescale 1ns/1ps

module ssb_sync_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic in_valid_i,
    input logic out_valid_i,
    input logic fs_idle_i,
    input logic beat_valid_i,
    input logic start_i
);

    // ******************************
    // Stage strobes
    // ******************************
    a_beat_not_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        beat_valid_i |-> !$past(fs_idle_i))
        else $error("beat valid while the frame sync was idle");

    a_start_with_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> beat_valid_i)
        else $error("block start without a beat");

    a_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i == $past(in_valid_i))               // One cycle latency
        else $error("correlator valid out of step with its input");

endmodule

bind ssb_frame_sync ssb_sync_props u_fs_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (1'b0),
    .out_valid_i  (1'b0),
    .fs_idle_i    (state_q == sync_pkg::FS_IDLE),
    .beat_valid_i (beat_valid_o),
    .start_i      (ssb_start_o)
);

bind pss_correlator ssb_sync_props u_corr_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .out_valid_i  (out_valid_o),
    .fs_idle_i    (1'b0),
    .beat_valid_i (1'b0),
    .start_i      (1'b0)
);

// ==== ssb_sync_top.sv ====
`timescale 1ns/1ps
`include "sync_params.svh"

module ssb_sync_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  sync_pkg::in_sample_t in_data_i,
    input  logic                 in_valid_i,
    output sync_pkg::sample_t    cic_data_o,
    output logic                 cic_valid_o,
    output logic                 peak_o,
    output logic                 ssb_start_o,
    output sync_pkg::energy_t    energy_o,
    output logic                 energy_valid_o,
    output logic                 pbch_valid_o,
    output logic                 sss_valid_o
);

    sync_pkg::sample_t   cic_data;
    logic                cic_valid;
    sync_pkg::sample_t   corr_data;
    logic                corr_valid;
    logic                corr_peak;
    sync_pkg::sym_beat_t fs_beat;
    logic                fs_valid;

    // Debug taps
    assign cic_data_o  = cic_data;
    assign cic_valid_o = cic_valid;
    assign peak_o      = corr_peak;

    // ******************************
    // Receive chain
    // ******************************
    cic_decimator u_cic (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .out_data_o  (cic_data),
        .out_valid_o (cic_valid)
    );

    pss_correlator u_corr (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (cic_data),
        .in_valid_i  (cic_valid),
        .out_data_o  (corr_data),
        .out_valid_o (corr_valid),
        .peak_o      (corr_peak)
    );

    ssb_frame_sync u_fs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_data_i    (corr_data),
        .in_valid_i   (corr_valid),
        .peak_i       (corr_peak),
        .beat_o       (fs_beat),
        .beat_valid_o (fs_valid),
        .ssb_start_o  (ssb_start_o)
    );

    symbol_energy u_energy (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .beat_i         (fs_beat),
        .beat_valid_i   (fs_valid),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_valid_o    (sss_valid_o)
    );

endmodule

// ==== symbol_energy.sv ====
`timescale 1ns/1ps
`include "sync_params.svh"

module symbol_energy (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  sync_pkg::sym_beat_t beat_i,
    input  logic                beat_valid_i,
    output sync_pkg::energy_t   energy_o,
    output logic                energy_valid_o,
    output logic                pbch_valid_o,
    output logic                sss_valid_o
);

    localparam int MAG_W = `SYNC_DATA_W + 1;

    typedef logic signed [MAG_W-1:0] wide_t;

    wide_t             re_w;
    wide_t             im_w;
    logic [MAG_W-1:0]  abs_re;
    logic [MAG_W-1:0]  abs_im;
    sync_pkg::energy_t acc_q;
    sync_pkg::energy_t acc_d;
    logic              sym_done;
    logic              is_sss;

    always_comb begin
        re_w   = wide_t'(beat_i.data.re);
        im_w   = wide_t'(beat_i.data.im);
        abs_re = re_w[MAG_W-1] ? -re_w : re_w;          // Extra bit keeps -32768 safe
        abs_im = im_w[MAG_W-1] ? -im_w : im_w;
        acc_d  = acc_q + sync_pkg::energy_t'(abs_re) + sync_pkg::energy_t'(abs_im);
    end

    assign sym_done = beat_valid_i && beat_i.last;
    assign is_sss   = (beat_i.idx == sync_pkg::sym_idx_t'(2));   // Middle symbol of the block

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_q          <= '0;
            energy_valid_o <= 1'b0;
            pbch_valid_o   <= 1'b0;
            sss_valid_o    <= 1'b0;
        end else begin
            energy_valid_o <= sym_done;
            pbch_valid_o   <= sym_done && !is_sss;
            sss_valid_o    <= sym_done && is_sss;
            if (beat_valid_i) begin
                acc_q <= beat_i.last ? '0 : acc_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sym_done) begin
            energy_o <= acc_d;
        end
    end

endmodule

// ==== ssb_frame_sync.sv ====
`timescale 1ns/1ps
`include "sync_params.svh"

module ssb_frame_sync (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  sync_pkg::sample_t   in_data_i,
    input  logic                in_valid_i,
    input  logic                peak_i,
    output sync_pkg::sym_beat_t beat_o,
    output logic                beat_valid_o,
    output logic                ssb_start_o
);

    localparam int CNT_W = $clog2(`SYNC_SYM_LEN);

    localparam logic [CNT_W-1:0] CP_LAST  = CNT_W'(`SYNC_CP_LEN - 1);
    localparam logic [CNT_W-1:0] SYM_LAST = CNT_W'(`SYNC_SYM_LEN - 1);

    localparam sync_pkg::sym_idx_t IDX_FIRST = sync_pkg::sym_idx_t'(1);
    localparam sync_pkg::sym_idx_t IDX_LAST  = sync_pkg::sym_idx_t'(`SYNC_SSB_SYMS);

    sync_pkg::fs_state_t state_q;
    logic [CNT_W-1:0]    cnt_q;
    sync_pkg::sym_idx_t  idx_q;
    logic                fwd;

    assign fwd = in_valid_i && (state_q == sync_pkg::FS_BODY);

    // ******************************
    // Block framing FSM
    // ******************************
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= sync_pkg::FS_IDLE;
            cnt_q        <= '0;
            idx_q        <= '0;
            beat_valid_o <= 1'b0;
            ssb_start_o  <= 1'b0;
        end else begin
            beat_valid_o <= fwd;
            ssb_start_o  <= fwd && (idx_q == IDX_FIRST) && (cnt_q == '0);
            if (in_valid_i) begin
                case (state_q)
                    sync_pkg::FS_IDLE: begin
                        if (peak_i) begin                       // PSS end sample dropped
                            state_q <= sync_pkg::FS_CP;
                            cnt_q   <= '0;
                            idx_q   <= IDX_FIRST;
                        end
                    end
                    sync_pkg::FS_CP: begin
                        if (cnt_q == CP_LAST) begin
                            state_q <= sync_pkg::FS_BODY;
                            cnt_q   <= '0;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    sync_pkg::FS_BODY: begin
                        if (cnt_q == SYM_LAST) begin
                            cnt_q <= '0;
                            if (idx_q == IDX_LAST) begin
                                state_q <= sync_pkg::FS_IDLE;
                            end else begin
                                state_q <= sync_pkg::FS_CP;
                                idx_q   <= idx_q + 1'b1;
                            end
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    default: state_q <= sync_pkg::FS_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fwd) begin
            beat_o.data <= in_data_i;
            beat_o.idx  <= idx_q;
            beat_o.last <= (cnt_q == SYM_LAST);                 // 16th body sample
        end
    end

endmodule

// ==== pss_correlator.sv ====
`timescale 1ns/1ps
`include "sync_params.svh"

module pss_correlator (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  sync_pkg::sample_t in_data_i,
    input  logic              in_valid_i,
    output sync_pkg::sample_t out_data_o,
    output logic              out_valid_o,
    output logic              peak_o
);

    localparam int LEN   = `SYNC_PSS_LEN;
    localparam int SUM_W = `SYNC_DATA_W + $clog2(`SYNC_PSS_LEN) + 1;

    localparam logic [LEN-1:0] TAPS = `SYNC_PSS_TAPS;

    typedef logic signed [SUM_W-1:0] sum_t;

    sync_pkg::sample_t line_q [LEN];
    sync_pkg::sample_t line_d [LEN];
    sum_t              c_re;
    sum_t              c_im;
    sum_t              abs_re;
    sum_t              abs_im;
    sync_pkg::metric_t metric;

    // ******************************
    // Delay line, oldest at index 0
    // ******************************
    always_comb begin
        for (int k = 0; k < LEN - 1; k++) begin
            line_d[k] = line_q[k + 1];
        end
        line_d[LEN - 1] = in_data_i;                    // Newest on tap 15
    end

    // Sign correlation against the replica
    always_comb begin
        c_re = '0;
        c_im = '0;
        for (int k = 0; k < LEN; k++) begin
            if (TAPS[k]) begin
                c_re = c_re + sum_t'(line_d[k].re);
                c_im = c_im + sum_t'(line_d[k].im);
            end else begin
                c_re = c_re - sum_t'(line_d[k].re);
                c_im = c_im - sum_t'(line_d[k].im);
            end
        end
        abs_re = c_re[SUM_W-1] ? -c_re : c_re;
        abs_im = c_im[SUM_W-1] ? -c_im : c_im;
        metric = sync_pkg::metric_t'(abs_re) + sync_pkg::metric_t'(abs_im);   // L1 magnitude
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            peak_o      <= 1'b0;
            for (int k = 0; k < LEN; k++) begin
                line_q[k] <= '0;
            end
        end else begin
            out_valid_o <= in_valid_i;
            peak_o      <= in_valid_i && (metric >= `SYNC_THRESH);
            if (in_valid_i) begin
                line_q <= line_d;
            end
        end
    end

    // Sample leaves with its own peak flag
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            out_data_o <= in_data_i;
        end
    end

endmodule

// ==== cic_decimator.sv ====
`timescale 1ns/1ps
`include "sync_params.svh"

module cic_decimator (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  sync_pkg::in_sample_t in_data_i,
    input  logic                 in_valid_i,
    output sync_pkg::sample_t    out_data_o,
    output logic                 out_valid_o
);

    localparam int ORDER = `SYNC_CIC_ORDER;
    localparam int PH_W  = $clog2(`SYNC_CIC_RATE);
    localparam int GROW  = ORDER * PH_W;                // log2 of the CIC gain
    localparam int ACC_W = `SYNC_IN_W + GROW;

    localparam logic [PH_W-1:0] PH_LAST = PH_W'(`SYNC_CIC_RATE - 1);

    typedef logic signed [ACC_W-1:0] acc_t;

    acc_t            integ_q [2][ORDER];
    acc_t            integ_d [2][ORDER];
    acc_t            comb_q  [2][ORDER];                // Differential delay of one
    acc_t            comb_in [2][ORDER];
    acc_t            res     [2];
    logic [PH_W-1:0] phase_q;
    logic            dec_take;

    assign dec_take = (phase_q == PH_LAST);

    // Index 0 carries re, index 1 carries im
    always_comb begin
        acc_t stage_in;
        for (int p = 0; p < 2; p++) begin
            stage_in = (p == 0) ? acc_t'(in_data_i.re) : acc_t'(in_data_i.im);
            for (int k = 0; k < ORDER; k++) begin
                integ_d[p][k] = integ_q[p][k] + stage_in;
                stage_in      = integ_d[p][k];
            end
            for (int k = 0; k < ORDER; k++) begin
                comb_in[p][k] = stage_in;
                stage_in      = stage_in - comb_q[p][k];
            end
            res[p] = stage_in >>> GROW;                 // Undo gain of 8
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            phase_q     <= '0;
            out_valid_o <= 1'b0;
            for (int p = 0; p < 2; p++) begin
                for (int k = 0; k < ORDER; k++) begin
                    integ_q[p][k] <= '0;
                    comb_q[p][k]  <= '0;
                end
            end
        end else begin
            out_valid_o <= in_valid_i && dec_take;
            if (in_valid_i) begin
                integ_q <= integ_d;
                phase_q <= dec_take ? '0 : phase_q + 1'b1;
                if (dec_take) begin
                    comb_q <= comb_in;                  // Comb runs at low rate
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && dec_take) begin
            out_data_o.re <= sync_pkg::iq_t'(res[0]);
            out_data_o.im <= sync_pkg::iq_t'(res[1]);
        end
    end

endmodule

// ==== sync_pkg.sv ====
`include "sync_params.svh"

package sync_pkg;

    // ******************************
    // Sample types
    // ******************************
    typedef struct packed {
        logic signed [`SYNC_IN_W-1:0] im;
        logic signed [`SYNC_IN_W-1:0] re;
    } in_sample_t;                              // Full rate input

    typedef logic signed [`SYNC_DATA_W-1:0] iq_t;

    typedef struct packed {
        iq_t im;
        iq_t re;
    } sample_t;                                 // Decimated sample

    typedef logic [`SYNC_METRIC_W-1:0] metric_t;
    typedef logic [1:0]                sym_idx_t;   // 1 to 3 within the block
    typedef logic [`SYNC_ENERGY_W-1:0] energy_t;

    // Frame sync to energy stage
    typedef struct packed {
        sample_t  data;
        sym_idx_t idx;
        logic     last;
    } sym_beat_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_CP,
        FS_BODY
    } fs_state_t;

endpackage

// ==== sync_params.svh ====
`ifndef SYNC_PARAMS_SVH
`define SYNC_PARAMS_SVH

// ******************************
// Sample widths
// ******************************
`define SYNC_IN_W       12              // Input I or Q part
`define SYNC_DATA_W     16              // I or Q after the CIC
`define SYNC_METRIC_W   24
`define SYNC_ENERGY_W   24

// CIC decimator
`define SYNC_CIC_RATE   2
`define SYNC_CIC_ORDER  3

// ******************************
// PSS replica and detection
// ******************************
`define SYNC_PSS_LEN    16
`define SYNC_PSS_TAPS   16'hE594        // Bit k set means tap k is +1
`define SYNC_THRESH     24'd3000        // Peak when L1 metric reaches this

// SS block framing at decimated rate
`define SYNC_CP_LEN     4
`define SYNC_SYM_LEN    16
`define SYNC_SSB_SYMS   3               // Symbols after the PSS

`endif
